//--- flist.f
src/riscv_csr_pkg.sv
src/csr_op_decode.sv
src/csr_trap_ctrl.sv
src/csr_machine_regs.sv
src/riscv_csrfile.sv
test/riscv_csrfile_checker.sv
test/tb_riscv_csrfile.sv

//--- run_sim.sh
#!/bin/sh
# compile with verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_riscv_csrfile \
    -f flist.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_riscv_csrfile > sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1

//--- test/tb_riscv_csrfile.sv
`timescale 1ns/1ps

module tb_riscv_csrfile;
    import riscv_csr_pkg::*;

    // one table row per driven cycle
    typedef struct {
        int              test;
        logic [2:0]      op;
        logic [11:0]     addr;
        logic [XLEN-1:0] wdata;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] alu;
        exc_flags_t      exc;
        // {external, timer}
        logic [1:0]      ints;
        logic [XLEN-1:0] exp_rdata;
        // pulses expected in the cycle after the row
        logic            exp_goto;
        logic            exp_ret;
        logic            chk_addr;
        logic [XLEN-1:0] exp_raddr;
        logic [XLEN-1:0] exp_taddr;
    } row_t;

    logic                  i_riscv_csr_clk;
    logic                  i_riscv_csr_rst;
    logic [CSR_ADDR_W-1:0] i_riscv_csr_address;
    logic [2:0]            i_riscv_csr_op;
    logic [XLEN-1:0]       i_riscv_csr_wdata;
    logic [XLEN-1:0]       i_riscv_csr_pc;
    logic [XLEN-1:0]       i_riscv_csr_address_alu;
    exc_flags_t            i_riscv_csr_exc;
    logic                  i_riscv_csr_external_int;
    logic                  i_riscv_csr_timer_int;
    logic [XLEN-1:0]       o_riscv_csr_rdata;
    logic [XLEN-1:0]       o_riscv_csr_return_address;
    logic [XLEN-1:0]       o_riscv_csr_trap_address;
    logic                  o_riscv_csr_goto_trap;
    logic                  o_riscv_csr_return_from_trap;

    row_t        rows[$];
    string       names[$];
    // side inputs and address checks for the rows still to be added
    row_t        side;
    logic [31:0] seed = 32'hb4869361;
    int          checks;
    int          errors;
    int          test_err;
    int          cycles;
    int          limit;

    riscv_csrfile dut_i (.*);

    always #5 i_riscv_csr_clk = ~i_riscv_csr_clk;

    // run limit is set once the table length is known
    always @(posedge i_riscv_csr_clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic rand_word(output logic [XLEN-1:0] w);
        seed = xorshift(seed);
        w[63:32] = seed;
        seed = xorshift(seed);
        w[31:0] = seed;
    endtask

    // misa from extension letters and mxl of 2
    function automatic logic [XLEN-1:0] misa_from_letters(input string ext);
        logic [XLEN-1:0] m;
        m = '0;
        m[XLEN-1:XLEN-2] = 2'd2;
        for (int k = 0; k < ext.len(); k++) begin
            m[ext[k] - 8'h41] = 1'b1;
        end
        return m;
    endfunction

    // mstatus seen after a trap entry or after an mret
    function automatic logic [XLEN-1:0] mstatus_next(input logic [XLEN-1:0] ms,
                                                      input logic take_trap);
        logic [XLEN-1:0] r;
        r = '0;
        r[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = PRIV_M;
        if (take_trap) begin
            r[MSTATUS_MPIE_BIT] = ms[MSTATUS_MIE_BIT];
        end else begin
            r[MSTATUS_MIE_BIT]  = ms[MSTATUS_MPIE_BIT];
            r[MSTATUS_MPIE_BIT] = 1'b1;
        end
        return r;
    endfunction

    task automatic set_side(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] alu,
                            input logic [4:0] exc, input logic [1:0] ints);
        side.pc   = pc;
        side.alu  = alu;
        side.exc  = exc_flags_t'(exc);
        side.ints = ints;
    endtask

    // applies to the next added row only
    task automatic expect_addrs(input logic [XLEN-1:0] raddr, input logic [XLEN-1:0] taddr);
        side.chk_addr  = 1'b1;
        side.exp_raddr = raddr;
        side.exp_taddr = taddr;
    endtask

    task automatic add_row(input logic [2:0] op, input logic [11:0] addr,
                           input logic [XLEN-1:0] wdata, input logic [XLEN-1:0] exp_rdata,
                           input logic exp_goto, input logic exp_ret);
        row_t r;
        r             = side;
        r.test        = names.size() - 1;
        r.op          = op;
        r.addr        = addr;
        r.wdata       = wdata;
        r.exp_rdata   = exp_rdata;
        r.exp_goto    = exp_goto;
        r.exp_ret     = exp_ret;
        rows.push_back(r);
        side.chk_addr = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        i_riscv_csr_op           <= r.op;
        i_riscv_csr_address      <= r.addr;
        i_riscv_csr_wdata        <= r.wdata;
        i_riscv_csr_pc           <= r.pc;
        i_riscv_csr_address_alu  <= r.alu;
        i_riscv_csr_exc          <= r.exc;
        i_riscv_csr_external_int <= r.ints[1];
        i_riscv_csr_timer_int    <= r.ints[0];
    endtask

    task automatic check_val(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
            test_err++;
        end
    endtask

    initial begin
        logic [XLEN-1:0] r1;
        logic [XLEN-1:0] r2;
        logic [XLEN-1:0] ms;
        logic [XLEN-1:0] me;
        row_t            idle;
        int              n;
        i_riscv_csr_clk          = 1'b0;
        i_riscv_csr_rst          = 1'b1;
        i_riscv_csr_address      = '0;
        i_riscv_csr_op           = '0;
        i_riscv_csr_wdata        = '0;
        i_riscv_csr_pc           = '0;
        i_riscv_csr_address_alu  = '0;
        i_riscv_csr_exc          = '0;
        i_riscv_csr_external_int = 1'b0;
        i_riscv_csr_timer_int    = 1'b0;
        checks   = 0;
        errors   = 0;
        test_err = 0;
        cycles   = 0;
        limit    = 0;
        set_side('0, '0, 5'b00000, 2'b00);
        side.chk_addr = 1'b0;
        ms = '0;
        me = '0;

        // ----------------------------------------
        // stimulus table
        // ----------------------------------------
        names.push_back("mscratch and id registers");
        rand_word(r1);
        rand_word(r2);
        // write ops also read so rdata shows the old value
        add_row(OP_WRITE, CSR_MSCRATCH, r1, '0, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MSCRATCH, '0, r1, 1'b0, 1'b0);
        add_row(OP_WRITE, CSR_MSCRATCH, r2, r1, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MSCRATCH, '0, r2, 1'b0, 1'b0);
        add_row(OP_READ, 12'h7C0, '0, '0, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MISA, '0, misa_from_letters("ACIMSU"), 1'b0, 1'b0);
        add_row(OP_READ, CSR_MVENDORID, '0, '0, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MCONFIGPTR, '0, '0, 1'b0, 1'b0);

        names.push_back("set and clear");
        add_row(OP_WRITE, CSR_MSTATUS, 64'h80, ms, 1'b0, 1'b0);
        ms = 64'h80;
        add_row(OP_SET, CSR_MSTATUS, 64'h08, ms, 1'b0, 1'b0);
        ms = ms | 64'h08;
        add_row(OP_CLEAR, CSR_MSTATUS, 64'h80, ms, 1'b0, 1'b0);
        ms = ms & ~64'h80;
        add_row(OP_READ, CSR_MSTATUS, '0, ms, 1'b0, 1'b0);
        add_row(OP_SET, CSR_MIE, 64'h880, me, 1'b0, 1'b0);
        me = me | 64'h880;
        add_row(OP_CLEAR, CSR_MIE, 64'h080, me, 1'b0, 1'b0);
        me = me & ~64'h080;
        add_row(OP_READ, CSR_MIE, '0, me, 1'b0, 1'b0);

        names.push_back("mepc and mtvec fields");
        add_row(OP_WRITE, CSR_MEPC, 64'h8000_1235, '0, 1'b0, 1'b0);
        expect_addrs(64'h8000_1234, '0);
        add_row(OP_READ, CSR_MEPC, '0, 64'h8000_1234, 1'b0, 1'b0);
        // vectored mode drops bit 1 and bits 7:2
        add_row(OP_WRITE, CSR_MTVEC, 64'h10FF, '0, 1'b0, 1'b0);
        expect_addrs(64'h8000_1234, 64'h1001);
        add_row(OP_READ, CSR_MTVEC, '0, 64'h1001, 1'b0, 1'b0);

        names.push_back("load misaligned trap");
        set_side(64'h8000_2000, 64'h1003, 5'b00010, 2'b00);
        add_row(3'b000, '0, '0, '0, 1'b1, 1'b0);
        set_side('0, '0, 5'b00000, 2'b00);
        expect_addrs(64'h8000_2000, 64'h1001);
        add_row(OP_READ, CSR_MEPC, '0, 64'h8000_2000, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MTVAL, '0, 64'h1003, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MCAUSE, '0, 64'd4, 1'b0, 1'b0);
        ms = mstatus_next(ms, 1'b1);
        add_row(OP_READ, CSR_MSTATUS, '0, ms, 1'b0, 1'b0);

        names.push_back("interrupt priority");
        add_row(OP_SET, CSR_MSTATUS, 64'h08, ms, 1'b0, 1'b0);
        ms = ms | 64'h08;
        add_row(OP_SET, CSR_MIE, 64'h080, me, 1'b0, 1'b0);
        // mip lags the lines by one edge
        set_side(64'h8000_3000, '0, 5'b00000, 2'b11);
        add_row(3'b000, '0, '0, '0, 1'b0, 1'b0);
        set_side(64'h8000_3004, '0, 5'b10000, 2'b11);
        add_row(3'b000, '0, '0, '0, 1'b1, 1'b0);
        set_side('0, '0, 5'b00000, 2'b00);
        add_row(OP_READ, CSR_MCAUSE, '0, (64'h1 << 63) | 64'd11, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MEPC, '0, 64'h8000_3004, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MTVAL, '0, 64'h1003, 1'b0, 1'b0);
        ms = mstatus_next(ms, 1'b1);
        add_row(OP_READ, CSR_MSTATUS, '0, ms, 1'b0, 1'b0);

        names.push_back("mret");
        add_row(OP_MRET, '0, '0, '0, 1'b0, 1'b1);
        ms = mstatus_next(ms, 1'b0);
        add_row(OP_READ, CSR_MSTATUS, '0, ms, 1'b0, 1'b0);
        // mpie low before the second return
        add_row(OP_CLEAR, CSR_MSTATUS, 64'h88, ms, 1'b0, 1'b0);
        ms = ms & ~64'h88;
        add_row(OP_MRET, '0, '0, '0, 1'b0, 1'b1);
        ms = mstatus_next(ms, 1'b0);
        add_row(OP_READ, CSR_MSTATUS, '0, ms, 1'b0, 1'b0);

        names.push_back("trap over mret");
        set_side(64'h8000_4000, '0, 5'b10000, 2'b00);
        add_row(OP_MRET, '0, '0, '0, 1'b1, 1'b0);
        set_side('0, '0, 5'b00000, 2'b00);
        ms = mstatus_next(ms, 1'b1);
        add_row(OP_READ, CSR_MSTATUS, '0, ms, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MCAUSE, '0, 64'd2, 1'b0, 1'b0);
        add_row(OP_READ, CSR_MEPC, '0, 64'h8000_4000, 1'b0, 1'b0);

        n     = rows.size();
        idle  = side;
        idle.op    = 3'b000;
        idle.addr  = '0;
        idle.wdata = '0;
        limit = n + 10 + 50;

        repeat (10) @(posedge i_riscv_csr_clk);
        i_riscv_csr_rst <= 1'b0;

        // ----------------------------------------
        // apply rows and check the pulses then rdata
        // ----------------------------------------
        for (int i = 0; i <= n; i++) begin
            @(posedge i_riscv_csr_clk);
            if (i < n) begin
                apply_row(rows[i]);
            end else begin
                apply_row(idle);
            end
            @(negedge i_riscv_csr_clk);
            if (i > 0) begin
                check_val($sformatf("row %0d goto_trap", i - 1),
                          64'(o_riscv_csr_goto_trap), 64'(rows[i-1].exp_goto));
                check_val($sformatf("row %0d return_from_trap", i - 1),
                          64'(o_riscv_csr_return_from_trap), 64'(rows[i-1].exp_ret));
                if (i == n || rows[i].test != rows[i-1].test) begin
                    $display("test %0d %s: %0d errors", rows[i-1].test,
                             names[rows[i-1].test], test_err);
                    test_err = 0;
                end
            end
            if (i < n) begin
                check_val($sformatf("row %0d rdata", i), o_riscv_csr_rdata, rows[i].exp_rdata);
                if (rows[i].chk_addr) begin
                    check_val($sformatf("row %0d return address", i),
                              o_riscv_csr_return_address, rows[i].exp_raddr);
                    check_val($sformatf("row %0d trap address", i),
                              o_riscv_csr_trap_address, rows[i].exp_taddr);
                end
            end
        end

        $display("tests %0d, checks %0d, errors %0d", names.size(), checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- test/riscv_csrfile_checker.sv
`timescale 1ns/1ps

module riscv_csrfile_checker (
    input logic                      i_riscv_csr_clk,
    input logic                      i_riscv_csr_rst,
    input riscv_csr_pkg::exc_flags_t i_exc,
    input logic [4:0]                i_int_state,
    input logic                      i_goto_trap,
    input logic                      i_return_from_trap
);
    logic int_enabled;

    // {mie, meie, mtie, meip, mtip}
    assign int_enabled = i_int_state[4] & ((i_int_state[3] & i_int_state[1]) |
                                           (i_int_state[2] & i_int_state[0]));

    // ----------------------------------------
    // trap pulse properties
    // ----------------------------------------
    a_pulses_exclusive: assert property (@(posedge i_riscv_csr_clk)
        disable iff (i_riscv_csr_rst) !(i_goto_trap && i_return_from_trap))
        else $error("goto_trap and return_from_trap high in the same cycle");

    // from the second reset edge the async clear has landed
    a_pulses_low_in_reset: assert property (@(posedge i_riscv_csr_clk)
        (i_riscv_csr_rst && $past(i_riscv_csr_rst)) |-> !(i_goto_trap || i_return_from_trap))
        else $error("trap pulse high while reset is asserted");

    // pulse is the registered trap condition
    a_goto_has_cause: assert property (@(posedge i_riscv_csr_clk)
        disable iff (i_riscv_csr_rst) i_goto_trap |-> $past((|i_exc) || int_enabled))
        else $error("goto_trap without an exception or enabled interrupt before it");

endmodule

bind riscv_csrfile riscv_csrfile_checker u_checker (
    .i_riscv_csr_clk    (i_riscv_csr_clk),
    .i_riscv_csr_rst    (i_riscv_csr_rst),
    .i_exc              (i_riscv_csr_exc),
    .i_int_state        (int_state),
    .i_goto_trap        (o_riscv_csr_goto_trap),
    .i_return_from_trap (o_riscv_csr_return_from_trap)
);

//--- src/riscv_csrfile.sv
`timescale 1ns/1ps

module riscv_csrfile (
    input  logic                                 i_riscv_csr_clk,
    input  logic                                 i_riscv_csr_rst,
    input  logic [riscv_csr_pkg::CSR_ADDR_W-1:0] i_riscv_csr_address,
    input  logic [2:0]                           i_riscv_csr_op,
    input  logic [riscv_csr_pkg::XLEN-1:0]       i_riscv_csr_wdata,
    input  logic [riscv_csr_pkg::XLEN-1:0]       i_riscv_csr_pc,
    input  logic [riscv_csr_pkg::XLEN-1:0]       i_riscv_csr_address_alu,
    input  riscv_csr_pkg::exc_flags_t            i_riscv_csr_exc,
    input  logic                                 i_riscv_csr_external_int,
    input  logic                                 i_riscv_csr_timer_int,
    output logic [riscv_csr_pkg::XLEN-1:0]       o_riscv_csr_rdata,
    output logic [riscv_csr_pkg::XLEN-1:0]       o_riscv_csr_return_address,
    output logic [riscv_csr_pkg::XLEN-1:0]       o_riscv_csr_trap_address,
    output logic                                 o_riscv_csr_goto_trap,
    output logic                                 o_riscv_csr_return_from_trap
);
    import riscv_csr_pkg::*;

    csr_access_t access;
    trap_cause_t cause;
    logic [4:0]  int_state;
    logic        trap_take;
    logic        tval_sel;

    // ----------------------------------------
    // op decode, set/clear merge old value
    // ----------------------------------------
    csr_op_decode u_op_decode (
        .i_riscv_csr_op        (csr_op_e'(i_riscv_csr_op)),
        .i_riscv_csr_address   (csr_addr_e'(i_riscv_csr_address)),
        .i_riscv_csr_wdata     (i_riscv_csr_wdata),
        .i_riscv_csr_rdata_cur (o_riscv_csr_rdata),
        .o_riscv_csr_access    (access)
    );

    // trap detect and cause select
    csr_trap_ctrl u_trap_ctrl (
        .i_riscv_csr_exc       (i_riscv_csr_exc),
        .i_riscv_csr_int_state (int_state),
        .o_riscv_csr_trap_take (trap_take),
        .o_riscv_csr_cause     (cause),
        .o_riscv_csr_tval_sel  (tval_sel)
    );

    // register storage and read mux
    // mepc is the return address, full mtvec the trap address
    csr_machine_regs u_machine_regs (
        .i_riscv_csr_clk              (i_riscv_csr_clk),
        .i_riscv_csr_rst              (i_riscv_csr_rst),
        .i_riscv_csr_access           (access),
        .i_riscv_csr_trap_take        (trap_take),
        .i_riscv_csr_cause            (cause),
        .i_riscv_csr_tval_sel         (tval_sel),
        .i_riscv_csr_pc               (i_riscv_csr_pc),
        .i_riscv_csr_address_alu      (i_riscv_csr_address_alu),
        .i_riscv_csr_external_int     (i_riscv_csr_external_int),
        .i_riscv_csr_timer_int        (i_riscv_csr_timer_int),
        .o_riscv_csr_rdata            (o_riscv_csr_rdata),
        .o_riscv_csr_int_state        (int_state),
        .o_riscv_csr_mepc             (o_riscv_csr_return_address),
        .o_riscv_csr_mtvec            (o_riscv_csr_trap_address),
        .o_riscv_csr_goto_trap        (o_riscv_csr_goto_trap),
        .o_riscv_csr_return_from_trap (o_riscv_csr_return_from_trap)
    );

endmodule

//--- src/csr_machine_regs.sv
`timescale 1ns/1ps

module csr_machine_regs (
    input  logic                           i_riscv_csr_clk,
    input  logic                           i_riscv_csr_rst,
    input  riscv_csr_pkg::csr_access_t     i_riscv_csr_access,
    input  logic                           i_riscv_csr_trap_take,
    input  riscv_csr_pkg::trap_cause_t     i_riscv_csr_cause,
    input  logic                           i_riscv_csr_tval_sel,
    input  logic [riscv_csr_pkg::XLEN-1:0] i_riscv_csr_pc,
    input  logic [riscv_csr_pkg::XLEN-1:0] i_riscv_csr_address_alu,
    input  logic                           i_riscv_csr_external_int,
    input  logic                           i_riscv_csr_timer_int,
    output logic [riscv_csr_pkg::XLEN-1:0] o_riscv_csr_rdata,
    output logic [4:0]                     o_riscv_csr_int_state,
    output logic [riscv_csr_pkg::XLEN-1:0] o_riscv_csr_mepc,
    output logic [riscv_csr_pkg::XLEN-1:0] o_riscv_csr_mtvec,
    output logic                           o_riscv_csr_goto_trap,
    output logic                           o_riscv_csr_return_from_trap
);
    import riscv_csr_pkg::*;

    // mstatus machine fields only
    logic               mstatus_mie;
    logic               mstatus_mpie;
    logic [1:0]         mstatus_mpp;
    // machine external and timer enables
    logic               mie_meie;
    logic               mie_mtie;
    // pending bits mirror the interrupt lines
    logic               mip_meip;
    logic               mip_mtip;
    logic [XLEN-1:0]    mtvec;
    logic [XLEN-1:0]    mscratch;
    logic [XLEN-1:0]    mepc;
    logic [XLEN-1:0]    mtval;
    logic               mcause_int;
    logic [CAUSE_W-1:0] mcause_code;
    // software write path
    logic [XLEN-1:0]    wdata;
    logic [XLEN-1:0]    mtvec_wr;

    assign wdata = i_riscv_csr_access.wdata;

    // mode bit 0 kept and bit 1 reserved
    // vectored mode drops the low base bits
    always_comb begin
        mtvec_wr = {wdata[XLEN-1:2], 1'b0, wdata[0]};
        if (wdata[0]) begin
            mtvec_wr[MTVEC_VEC_ALIGN-1:2] = '0;
        end
    end

    // ----------------------------------------
    // state update priority trap > mret > sw write
    // ----------------------------------------
    always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst) begin
        if (i_riscv_csr_rst) begin
            mstatus_mie                  <= 1'b0;
            mstatus_mpie                 <= 1'b0;
            mstatus_mpp                  <= 2'b00;
            mie_meie                     <= 1'b0;
            mie_mtie                     <= 1'b0;
            mip_meip                     <= 1'b0;
            mip_mtip                     <= 1'b0;
            mtvec                        <= '0;
            mscratch                     <= '0;
            mepc                         <= '0;
            mtval                        <= '0;
            mcause_int                   <= 1'b0;
            mcause_code                  <= '0;
            o_riscv_csr_goto_trap        <= 1'b0;
            o_riscv_csr_return_from_trap <= 1'b0;
        end else begin
            // sampled every edge with no sw write path
            mip_meip <= i_riscv_csr_external_int;
            mip_mtip <= i_riscv_csr_timer_int;

            // one cycle pulses and mret lost under a trap
            o_riscv_csr_goto_trap        <= i_riscv_csr_trap_take;
            o_riscv_csr_return_from_trap <= i_riscv_csr_access.mret & ~i_riscv_csr_trap_take;

            if (i_riscv_csr_trap_take) begin
                mepc         <= i_riscv_csr_pc;
                // stack the enable without nesting
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mstatus_mpp  <= PRIV_M;
                mcause_int   <= i_riscv_csr_cause.is_int;
                mcause_code  <= i_riscv_csr_cause.code;
                // misaligned load/store only
                if (i_riscv_csr_tval_sel) begin
                    mtval <= i_riscv_csr_address_alu;
                end
            end else if (i_riscv_csr_access.mret) begin
                // pop the enable stack
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
                mstatus_mpp  <= PRIV_M;
            end else if (i_riscv_csr_access.we) begin
                case (i_riscv_csr_access.addr)
                    CSR_MSTATUS: begin
                        mstatus_mie  <= wdata[MSTATUS_MIE_BIT];
                        mstatus_mpie <= wdata[MSTATUS_MPIE_BIT];
                        mstatus_mpp  <= wdata[MSTATUS_MPP_HI:MSTATUS_MPP_LO];
                    end
                    CSR_MIE: begin
                        mie_meie <= wdata[MIE_MEI_BIT];
                        mie_mtie <= wdata[MIE_MTI_BIT];
                    end
                    CSR_MTVEC: begin
                        mtvec <= mtvec_wr;
                    end
                    CSR_MSCRATCH: begin
                        mscratch <= wdata;
                    end
                    CSR_MEPC: begin
                        // 16-bit instruction alignment
                        mepc <= {wdata[XLEN-1:1], 1'b0};
                    end
                    CSR_MCAUSE: begin
                        mcause_int  <= wdata[XLEN-1];
                        mcause_code <= wdata[CAUSE_W-1:0];
                    end
                    CSR_MTVAL: begin
                        mtval <= wdata;
                    end
                    default: begin
                        // id regs and mip ignore writes
                    end
                endcase
            end
        end
    end

    // ----------------------------------------
    // read mux
    // ----------------------------------------
    always_comb begin
        o_riscv_csr_rdata = '0;
        if (i_riscv_csr_access.rd) begin
            case (i_riscv_csr_access.addr)
                CSR_MISA: begin
                    o_riscv_csr_rdata = MISA_VALUE;
                end
                CSR_MSTATUS: begin
                    o_riscv_csr_rdata[MSTATUS_MIE_BIT]                = mstatus_mie;
                    o_riscv_csr_rdata[MSTATUS_MPIE_BIT]               = mstatus_mpie;
                    o_riscv_csr_rdata[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mstatus_mpp;
                end
                CSR_MIE: begin
                    o_riscv_csr_rdata[MIE_MEI_BIT] = mie_meie;
                    o_riscv_csr_rdata[MIE_MTI_BIT] = mie_mtie;
                end
                CSR_MIP: begin
                    o_riscv_csr_rdata[MIE_MEI_BIT] = mip_meip;
                    o_riscv_csr_rdata[MIE_MTI_BIT] = mip_mtip;
                end
                CSR_MTVEC:    o_riscv_csr_rdata = mtvec;
                CSR_MSCRATCH: o_riscv_csr_rdata = mscratch;
                CSR_MEPC:     o_riscv_csr_rdata = mepc;
                CSR_MTVAL:    o_riscv_csr_rdata = mtval;
                CSR_MCAUSE: begin
                    o_riscv_csr_rdata[XLEN-1]      = mcause_int;
                    o_riscv_csr_rdata[CAUSE_W-1:0] = mcause_code;
                end
                // vendor, arch, impl ids and mconfigptr read zero
                default: o_riscv_csr_rdata = '0;
            endcase
        end
    end

    // packed for the trap control
    assign o_riscv_csr_int_state = {mstatus_mie, mie_meie, mie_mtie, mip_meip, mip_mtip};
    assign o_riscv_csr_mepc      = mepc;
    assign o_riscv_csr_mtvec     = mtvec;

endmodule

//--- src/csr_trap_ctrl.sv
`timescale 1ns/1ps

module csr_trap_ctrl (
    input  riscv_csr_pkg::exc_flags_t  i_riscv_csr_exc,
    // {mstatus.mie, meie, mtie, meip, mtip}
    input  logic [4:0]                 i_riscv_csr_int_state,
    output logic                       o_riscv_csr_trap_take,
    output riscv_csr_pkg::trap_cause_t o_riscv_csr_cause,
    output logic                       o_riscv_csr_tval_sel
);
    import riscv_csr_pkg::*;

    logic glb_mie;
    logic meie;
    logic mtie;
    logic meip;
    logic mtip;
    logic ext_int;
    logic tmr_int;

    assign {glb_mie, meie, mtie, meip, mtip} = i_riscv_csr_int_state;

    // ----------------------------------------
    // interrupt qualification
    // ----------------------------------------
    // global enable, local enable and pending all needed
    assign ext_int = glb_mie & meie & meip;
    assign tmr_int = glb_mie & mtie & mtip;

    // any enabled interrupt or any exception level traps
    assign o_riscv_csr_trap_take = ext_int | tmr_int | (|i_riscv_csr_exc);

    // ----------------------------------------
    // cause priority
    // ----------------------------------------
    // ext int > timer > illegal > inst misaligned > ecall > load > store
    always_comb begin
        o_riscv_csr_cause    = '0;
        o_riscv_csr_tval_sel = 1'b0;
        if (ext_int) begin
            o_riscv_csr_cause.is_int = 1'b1;
            o_riscv_csr_cause.code   = CAUSE_W'(MIE_MEI_BIT);
        end else if (tmr_int) begin
            o_riscv_csr_cause.is_int = 1'b1;
            o_riscv_csr_cause.code   = CAUSE_W'(MIE_MTI_BIT);
        end else if (i_riscv_csr_exc.illegal) begin
            o_riscv_csr_cause.code = CAUSE_ILLEGAL;
        end else if (i_riscv_csr_exc.inst_misaligned) begin
            o_riscv_csr_cause.code = CAUSE_INST_MISALIGNED;
        end else if (i_riscv_csr_exc.ecall_m) begin
            o_riscv_csr_cause.code = CAUSE_ECALL_M;
        end else if (i_riscv_csr_exc.load_misaligned) begin
            o_riscv_csr_cause.code = CAUSE_LOAD_MISALIGNED;
            // faulting address goes to mtval
            o_riscv_csr_tval_sel   = 1'b1;
        end else if (i_riscv_csr_exc.store_misaligned) begin
            o_riscv_csr_cause.code = CAUSE_STORE_MISALIGNED;
            o_riscv_csr_tval_sel   = 1'b1;
        end
    end

endmodule

//--- src/csr_op_decode.sv
`timescale 1ns/1ps

module csr_op_decode (
    input  riscv_csr_pkg::csr_op_e         i_riscv_csr_op,
    input  riscv_csr_pkg::csr_addr_e       i_riscv_csr_address,
    input  logic [riscv_csr_pkg::XLEN-1:0] i_riscv_csr_wdata,
    input  logic [riscv_csr_pkg::XLEN-1:0] i_riscv_csr_rdata_cur,
    output riscv_csr_pkg::csr_access_t     o_riscv_csr_access
);
    import riscv_csr_pkg::*;

    // strobes and merged write data are combinational
    always_comb begin
        o_riscv_csr_access       = '0;
        o_riscv_csr_access.addr  = i_riscv_csr_address;
        o_riscv_csr_access.wdata = i_riscv_csr_wdata;
        case (i_riscv_csr_op)
            OP_WRITE: begin
                o_riscv_csr_access.rd = 1'b1;
                o_riscv_csr_access.we = 1'b1;
            end
            OP_SET: begin
                o_riscv_csr_access.rd    = 1'b1;
                o_riscv_csr_access.we    = 1'b1;
                // old value or mask
                o_riscv_csr_access.wdata = i_riscv_csr_rdata_cur | i_riscv_csr_wdata;
            end
            OP_CLEAR: begin
                o_riscv_csr_access.rd    = 1'b1;
                o_riscv_csr_access.we    = 1'b1;
                // old value with mask bits knocked out
                o_riscv_csr_access.wdata = i_riscv_csr_rdata_cur & ~i_riscv_csr_wdata;
            end
            OP_READ: begin
                o_riscv_csr_access.rd = 1'b1;
            end
            OP_MRET: begin
                // no read or write side effects
                o_riscv_csr_access.mret = 1'b1;
            end
            default: begin
                // inert op codes leave every strobe low
            end
        endcase
    end

endmodule

//--- src/riscv_csr_pkg.sv
package riscv_csr_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int XLEN       = 64;
    localparam int CSR_ADDR_W = 12;
    localparam int CAUSE_W    = 4;

    // implemented machine csr addresses
    typedef enum logic [CSR_ADDR_W-1:0] {
        CSR_MSTATUS    = 12'h300,
        CSR_MISA       = 12'h301,
        CSR_MIE        = 12'h304,
        CSR_MTVEC      = 12'h305,
        CSR_MSCRATCH   = 12'h340,
        CSR_MEPC       = 12'h341,
        CSR_MCAUSE     = 12'h342,
        CSR_MTVAL      = 12'h343,
        CSR_MIP        = 12'h344,
        CSR_MVENDORID  = 12'hF11,
        CSR_MARCHID    = 12'hF12,
        CSR_MIMPID     = 12'hF13,
        CSR_MCONFIGPTR = 12'hF15
    } csr_addr_e;

    // csr operation codes, anything else is a no-op
    typedef enum logic [2:0] {
        OP_WRITE = 3'b001,
        OP_SET   = 3'b010,
        OP_CLEAR = 3'b011,
        OP_READ  = 3'b101,
        OP_MRET  = 3'b111
    } csr_op_e;

    // mstatus bit positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO   = 11;
    localparam int MSTATUS_MPP_HI   = 12;

    // shared by mie, mip and interrupt cause codes
    localparam int MIE_MTI_BIT = 7;
    localparam int MIE_MEI_BIT = 11;

    // exception cause codes
    localparam logic [CAUSE_W-1:0] CAUSE_INST_MISALIGNED  = 4'd0;
    localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL          = 4'd2;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_MISALIGNED  = 4'd4;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_MISALIGNED = 4'd6;
    localparam logic [CAUSE_W-1:0] CAUSE_ECALL_M          = 4'd11;

    localparam logic [1:0] PRIV_M = 2'b11;

    // rv64 (mxl=2) with A, C, I, M, S, U
    localparam logic [XLEN-1:0] MISA_VALUE = 64'h8000_0000_0014_1105;

    // vectored mtvec base is aligned to this bit
    localparam int MTVEC_VEC_ALIGN = 8;

    // ----------------------------------------
    // bundles
    // ----------------------------------------
    typedef struct packed {
        logic            rd;
        logic            we;
        logic            mret;
        csr_addr_e       addr;
        logic [XLEN-1:0] wdata;
    } csr_access_t;

    typedef struct packed {
        logic illegal;
        logic inst_misaligned;
        logic ecall_m;
        logic load_misaligned;
        logic store_misaligned;
    } exc_flags_t;

    typedef struct packed {
        logic               is_int;
        logic [CAUSE_W-1:0] code;
    } trap_cause_t;

endpackage
